// File: common/fds_consts.svh
// FDS drive constants for the register map, disk timing, block lengths and memory bases
`ifndef FDS_CONSTS_SVH
`define FDS_CONSTS_SVH

// CPU register map
`define FDS_REG_TLO   16'h4020
`define FDS_REG_THI   16'h4021
`define FDS_REG_TCTL  16'h4022
`define FDS_REG_IOEN  16'h4023
`define FDS_REG_CTRL  16'h4025
`define FDS_REG_SIDE  16'h4027
`define FDS_REG_STAT  16'h4030
`define FDS_REG_DATA  16'h4031
`define FDS_REG_DRIVE 16'h4032
`define FDS_REG_EXT   16'h4033

// Disk timing in ce cycles, about 149 CPU cycles per real byte
`define FDS_PREGAP_FAST 20'd65535
`define FDS_PREGAP_ORIG 20'd525420
`define FDS_BYTE_FAST   20'd99
`define FDS_BYTE_ORIG   20'd149

// Disk image geometry
`define FDS_DISK_END   16'd65499
`define FDS_SIDE_BYTES 18'd65500
`define FDS_SIDE_BASE  18'd16

// Last byte index of the fixed-length blocks (CRC bytes are absent from the image)
`define FDS_BLK1_LAST 16'h0037
`define FDS_BLK2_LAST 16'h0001
`define FDS_BLK3_LAST 16'h000F

// Upper address bits of the disk image in PRG space
`define FDS_DISK_BASE 4'b1111

`endif

// File: common/fds_bus_pkg.sv
// CPU bus access and PRG memory mapping types of the FDS drive
package fds_bus_pkg;

	// One CPU access, qualified by a one-clock ce strobe
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        read;
		logic        write;
		logic        ce;   // Marks a bus cycle
	} cpu_bus_t;

	// Mapped PRG memory access
	typedef struct packed {
		logic [21:0] addr;
		logic        allow;  // Memory may serve this access
	} prg_map_t;

endpackage

// File: common/fds_disk_pkg.sv
// Disk control, block type and drive status types of the FDS drive
package fds_disk_pkg;

	// Fields of the $4025 control register that the drive keeps
	typedef struct packed {
		logic disk_irq_en;  // Bit 7
		logic byte_xfer;    // Bit 6
		logic disk_reset;   // Bit 1
		logic motor_on;     // Bit 0
	} disk_ctrl_t;

	// Block type taken from byte 0 of each block
	typedef enum logic [2:0] {
		BLK_NONE      = 3'd0,
		BLK_VOLUME    = 3'd1,
		BLK_FILE_CNT  = 3'd2,
		BLK_FILE_HDR  = 3'd3,
		BLK_FILE_DATA = 3'd4
	} block_type_t;

	// Drive state reported on status reads and used for image addressing
	typedef struct packed {
		logic        xfer_flag;   // Byte ready for the CPU
		logic        disk_end;
		logic        disk_ready;  // Motor on, not in reset, not at end
		logic [15:0] disk_pos;
	} drive_status_t;

endpackage

// File: src/fds_reg_ctrl.sv
// FDS register decoder holding the I/O enable, disk control and disk side registers
`include "fds_consts.svh"

module fds_reg_ctrl (
	input  logic                     clk,
	input  logic                     reset,
	input  fds_bus_pkg::cpu_bus_t    bus,
	input  logic [1:0]               side_max,
	output fds_disk_pkg::disk_ctrl_t ctrl,
	output logic                     io_en,
	output logic [1:0]               disk_side,
	output logic                     timer_lo_wr,
	output logic                     timer_hi_wr,
	output logic                     timer_ctl_wr,
	output logic                     stat_rd,
	output logic                     data_rd,
	output logic [7:0]               wdata
);

	logic       bus_wr;
	logic       bus_rd;
	logic [1:0] side_req;

	assign bus_wr = bus.ce & bus.write;
	assign bus_rd = bus.ce & bus.read;

	// Timer events go straight to the timer on the write cycle
	assign timer_lo_wr  = bus_wr & (bus.addr == `FDS_REG_TLO);
	assign timer_hi_wr  = bus_wr & (bus.addr == `FDS_REG_THI);
	assign timer_ctl_wr = bus_wr & (bus.addr == `FDS_REG_TCTL);
	assign wdata        = bus.wdata;

	// Disk byte is captured in the same cycle as the read
	assign data_rd = bus_rd & (bus.addr == `FDS_REG_DATA);

	// Requested side, held at the last side of the image
	assign side_req = (bus.wdata[1:0] > side_max) ? side_max : bus.wdata[1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl      <= '0;
			io_en     <= 1'b0;
			disk_side <= 2'd0;
			stat_rd   <= 1'b0;
		end else if (bus.ce) begin
			// Status read acts on the following ce
			stat_rd <= bus.read & (bus.addr == `FDS_REG_STAT);

			if (bus_wr) begin
				case (bus.addr)
					`FDS_REG_IOEN: io_en <= bus.wdata[0];
					`FDS_REG_CTRL: begin
						ctrl.motor_on    <= bus.wdata[0];
						ctrl.disk_reset  <= bus.wdata[1];
						ctrl.byte_xfer   <= bus.wdata[6];
						ctrl.disk_irq_en <= bus.wdata[7];
					end
					`FDS_REG_SIDE: disk_side <= side_req;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: src/fds_timer.sv
// FDS timer IRQ with 16-bit reload latch, down-counter and repeat mode
module fds_timer (
	input  logic       clk,
	input  logic       reset,
	input  logic       ce,
	input  logic       io_en,
	input  logic       timer_lo_wr,
	input  logic       timer_hi_wr,
	input  logic       timer_ctl_wr,
	input  logic       stat_rd,
	input  logic [7:0] wdata,
	output logic       timer_irq
);

	logic [15:0] latch;
	logic [15:0] count;
	logic        irq_en;
	logic        irq_repeat;
	logic        start;

	assign start = wdata[1] & io_en;  // Enable bit honoured only with I/O enabled

	always_ff @(posedge clk) begin
		if (reset) begin
			timer_irq  <= 1'b0;
			irq_en     <= 1'b0;
			irq_repeat <= 1'b0;
		end else if (ce) begin
			if (irq_en) begin
				if (count == 16'd0) begin
					timer_irq <= 1'b1;
					if (!irq_repeat)
						irq_en <= 1'b0;  // One-shot stops here
				end
			end

			if (timer_ctl_wr) begin
				irq_repeat <= wdata[0];
				irq_en     <= start;
				if (!start)
					timer_irq <= 1'b0;
			end

			// I/O disable stops the timer and drops a pending IRQ
			if (!io_en) begin
				irq_en    <= 1'b0;
				timer_irq <= 1'b0;
			end

			if (stat_rd)
				timer_irq <= 1'b0;
		end
	end

	// Latch and counter
	always_ff @(posedge clk) begin
		if (ce) begin
			if (timer_lo_wr)
				latch[7:0] <= wdata;
			if (timer_hi_wr)
				latch[15:8] <= wdata;

			if (timer_ctl_wr && start)
				count <= latch;
			else if (irq_en)
				count <= (count == 16'd0) ? latch : count - 16'd1;  // Reload on expiry
		end
	end

endmodule

// File: disk/fds_disk_xfer.sv
// FDS disk read engine with pre-gap and byte clock, disk position and block tracking
`include "fds_consts.svh"

module fds_disk_xfer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        ce,
	input  logic                        fast,
	input  fds_disk_pkg::disk_ctrl_t    ctrl,
	input  logic                        data_rd,
	input  logic                        stat_rd,
	input  logic [7:0]                  disk_byte,
	output fds_disk_pkg::drive_status_t status,
	output logic                        disk_irq
);

	logic [19:0]               pregap_delay;
	logic [19:0]               byte_delay;
	logic [19:0]               xfer_cnt;
	logic                      after_pregap;
	logic                      xfer_flag;
	logic                      new_byte;
	logic                      data_rd_d;
	logic                      byte_xfer_d;
	logic                      xfer_start;
	logic [15:0]               byte_cnt;
	logic [15:0]               file_size;
	logic [15:0]               disk_pos;
	logic                      disk_end;
	logic                      block_end;
	logic                      last_byte;
	fds_disk_pkg::block_type_t block_type;

	assign pregap_delay = fast ? `FDS_PREGAP_FAST : `FDS_PREGAP_ORIG;
	assign byte_delay   = fast ? `FDS_BYTE_FAST : `FDS_BYTE_ORIG;

	assign xfer_start = ctrl.byte_xfer & ~byte_xfer_d;  // New transfer through $4025
	assign disk_end   = (disk_pos == `FDS_DISK_END);

	// Current byte is the last one of its block
	always_comb begin
		case (block_type)
			fds_disk_pkg::BLK_VOLUME:    last_byte = (byte_cnt == `FDS_BLK1_LAST);
			fds_disk_pkg::BLK_FILE_CNT:  last_byte = (byte_cnt == `FDS_BLK2_LAST);
			fds_disk_pkg::BLK_FILE_HDR:  last_byte = (byte_cnt == `FDS_BLK3_LAST);
			fds_disk_pkg::BLK_FILE_DATA: last_byte = (byte_cnt == file_size);
			default:                     last_byte = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			xfer_cnt     <= 20'd0;
			after_pregap <= 1'b0;
			xfer_flag    <= 1'b0;
			new_byte     <= 1'b0;
			data_rd_d    <= 1'b0;
			byte_xfer_d  <= 1'b0;
			byte_cnt     <= 16'd0;
			disk_pos     <= 16'd0;
			block_end    <= 1'b0;
			block_type   <= fds_disk_pkg::BLK_NONE;
		end else if (ce) begin
			byte_xfer_d <= ctrl.byte_xfer;
			data_rd_d   <= data_rd;

			if (xfer_start) begin
				xfer_flag  <= 1'b0;
				new_byte   <= 1'b0;
				byte_cnt   <= 16'd0;
				block_end  <= 1'b0;
				block_type <= fds_disk_pkg::BLK_NONE;
			end

			if (stat_rd)
				xfer_flag <= 1'b0;

			// Block type from byte 0
			if (data_rd && byte_cnt == 16'd0)
				block_type <= fds_disk_pkg::block_type_t'(disk_byte[2:0]);

			// Advance one ce after the CPU read
			if (data_rd_d) begin
				xfer_flag <= 1'b0;
				if (new_byte) begin
					new_byte <= 1'b0;
					byte_cnt <= byte_cnt + 16'd1;
					if (!disk_end && !block_end)
						disk_pos <= disk_pos + 16'd1;
					if (last_byte)
						block_end <= 1'b1;
				end
			end

			if (!ctrl.motor_on) begin
				xfer_cnt <= 20'd0;
			end else if (ctrl.disk_reset) begin
				xfer_cnt     <= 20'd0;
				disk_pos     <= 16'd0;
				after_pregap <= 1'b0;
			end else if (!after_pregap) begin
				if (xfer_cnt == pregap_delay) begin  // Start of disk reached
					after_pregap <= 1'b1;
					xfer_cnt     <= 20'd0;
				end else begin
					xfer_cnt <= xfer_cnt + 20'd1;
				end
			end else if (xfer_cnt == byte_delay) begin
				xfer_cnt <= 20'd0;
				if (ctrl.byte_xfer) begin
					xfer_flag <= 1'b1;
					new_byte  <= 1'b1;
				end
			end else begin
				xfer_cnt <= xfer_start ? 20'd0 : xfer_cnt + 20'd1;
			end
		end
	end

	// File size from bytes $0D and $0E of a file header
	always_ff @(posedge clk) begin
		if (ce && data_rd && block_type == fds_disk_pkg::BLK_FILE_HDR) begin
			if (byte_cnt == 16'h000D)
				file_size[7:0] <= disk_byte;
			if (byte_cnt == 16'h000E)
				file_size[15:8] <= disk_byte;
		end
	end

	assign status.xfer_flag  = xfer_flag;
	assign status.disk_end   = disk_end;
	assign status.disk_ready = ctrl.motor_on & ~ctrl.disk_reset & ~disk_end;
	assign status.disk_pos   = disk_pos;

	assign disk_irq = xfer_flag & ctrl.disk_irq_en;

endmodule

// File: src/fds_bus_map.sv
// FDS PRG address mapping and status register read multiplexer
`include "fds_consts.svh"

module fds_bus_map (
	input  fds_bus_pkg::cpu_bus_t       bus,
	input  fds_disk_pkg::drive_status_t status,
	input  logic                        timer_irq,
	input  logic [1:0]                  disk_side,
	input  logic                        eject,
	output logic [7:0]                  prg_dout,
	output logic                        prg_drive,
	output fds_bus_pkg::prg_map_t       prg_map
);

	logic        is_stat;
	logic        is_data;
	logic        is_drive;
	logic        is_ext;
	logic        is_ram;
	logic        ready;
	logic [17:0] side_off;
	logic [17:0] img_off;
	logic [21:0] mem_addr;

	assign is_stat  = (bus.addr == `FDS_REG_STAT);
	assign is_data  = (bus.addr == `FDS_REG_DATA);
	assign is_drive = (bus.addr == `FDS_REG_DRIVE);
	assign is_ext   = (bus.addr == `FDS_REG_EXT);

	assign ready = status.disk_ready & ~eject;

	always_comb begin
		prg_dout = 8'h00;
		if (is_stat)
			prg_dout = {status.xfer_flag, status.disk_end, 5'd0, timer_irq};
		else if (is_drive)
			prg_dout = {4'h4, 1'b0, eject, ~ready, eject};
		else if (is_ext)
			prg_dout = 8'h80;  // Battery good
	end

	assign prg_drive = is_stat | is_drive | is_ext;

	// $6000-$DFFF is work RAM, the rest of upper space is BIOS
	assign is_ram   = bus.addr[15] ^ (&bus.addr[14:13]);
	assign mem_addr = is_ram ? {7'b1000001, bus.addr[14:0]} : {9'd0, bus.addr[12:0]};

	// Image offset is header plus one side length per side
	assign side_off = `FDS_SIDE_BASE + 18'(disk_side) * `FDS_SIDE_BYTES;
	assign img_off  = 18'(status.disk_pos) + side_off;

	assign prg_map.addr  = is_data ? {`FDS_DISK_BASE, img_off} : mem_addr;
	assign prg_map.allow = ((bus.addr[15] | is_data) & ~bus.write) | is_ram;

endmodule

// File: src/fds_top.sv
// FDS drive top connecting the register decoder, timer, disk engine and bus map
module fds_top (
	input  logic                  clk,
	input  logic                  reset,
	input  fds_bus_pkg::cpu_bus_t bus,
	input  logic [7:0]            disk_byte,
	input  logic                  fast,
	input  logic                  eject,
	input  logic [1:0]            side_max,
	output logic [7:0]            prg_dout,
	output logic                  prg_drive,
	output fds_bus_pkg::prg_map_t prg_map,
	output logic                  irq
);

	fds_disk_pkg::disk_ctrl_t    ctrl;
	fds_disk_pkg::drive_status_t status;
	logic                        io_en;
	logic [1:0]                  disk_side;
	logic                        timer_lo_wr;
	logic                        timer_hi_wr;
	logic                        timer_ctl_wr;
	logic                        stat_rd;
	logic                        data_rd;
	logic [7:0]                  wdata;
	logic                        timer_irq;
	logic                        disk_irq;

	fds_reg_ctrl u_reg_ctrl (
		.clk          (clk),
		.reset        (reset),
		.bus          (bus),
		.side_max     (side_max),
		.ctrl         (ctrl),
		.io_en        (io_en),
		.disk_side    (disk_side),
		.timer_lo_wr  (timer_lo_wr),
		.timer_hi_wr  (timer_hi_wr),
		.timer_ctl_wr (timer_ctl_wr),
		.stat_rd      (stat_rd),
		.data_rd      (data_rd),
		.wdata        (wdata)
	);

	fds_timer u_timer (
		.clk          (clk),
		.reset        (reset),
		.ce           (bus.ce),
		.io_en        (io_en),
		.timer_lo_wr  (timer_lo_wr),
		.timer_hi_wr  (timer_hi_wr),
		.timer_ctl_wr (timer_ctl_wr),
		.stat_rd      (stat_rd),
		.wdata        (wdata),
		.timer_irq    (timer_irq)
	);

	fds_disk_xfer u_disk_xfer (
		.clk       (clk),
		.reset     (reset),
		.ce        (bus.ce),
		.fast      (fast),
		.ctrl      (ctrl),
		.data_rd   (data_rd),
		.stat_rd   (stat_rd),
		.disk_byte (disk_byte),
		.status    (status),
		.disk_irq  (disk_irq)
	);

	fds_bus_map u_bus_map (
		.bus       (bus),
		.status    (status),
		.timer_irq (timer_irq),
		.disk_side (disk_side),
		.eject     (eject),
		.prg_dout  (prg_dout),
		.prg_drive (prg_drive),
		.prg_map   (prg_map)
	);

	assign irq = timer_irq | disk_irq;

endmodule

// File: tb/fds_monitor.sv
// FDS drive checker with a timer reference model and status and mapping reference functions
`include "fds_consts.svh"

module fds_monitor (
	input  logic                  clk,
	input  logic                  reset,
	input  fds_bus_pkg::cpu_bus_t bus,
	input  logic [7:0]            prg_dout,
	input  logic                  prg_drive,
	input  fds_bus_pkg::prg_map_t prg_map,
	input  logic                  irq,
	input  logic                  eject,
	input  logic [15:0]           pos_exp,
	input  logic [1:0]            side_exp,
	input  logic                  xfer_exp,
	input  logic                  ready_exp,
	input  logic                  cmp_en,
	input  logic [31:0]           cmp_got,
	input  logic [31:0]           cmp_exp,
	output int                    checks,
	output int                    errors
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] cyc;
	logic [31:0] deadline;  // Cycle of the next expiry
	logic [15:0] latch;
	logic        io_en;
	logic        running;
	logic        rep;
	logic        tirq;
	logic        stat_pend;
	logic        disk_irq_en;

	initial begin
		checks = 0;
		errors = 0;
	end

	function automatic logic [31:0] timer_deadline(input logic [31:0] now,
		input logic [15:0] period);
		return now + 32'(period) + 32'd1;
	endfunction

	function automatic logic [7:0] stat_byte(input logic xfer, input logic dend, input logic t);
		return {xfer, dend, 5'd0, t};
	endfunction

	function automatic logic [7:0] drive_byte(input logic ready, input logic ej);
		return {4'h4, 1'b0, ej, ~(ready & ~ej), ej};  // Bit 6 always high
	endfunction

	function automatic logic [21:0] map_addr(input logic [15:0] a, input logic [15:0] pos,
		input logic [1:0] side);
		logic [21:0] off;
		off = 22'(pos) + 22'd16 + 22'd65500 * 22'(side);
		if (a == `FDS_REG_DATA)
			return {4'hF, off[17:0]};
		if (a >= 16'hE000)
			return 22'(a - 16'hE000);  // BIOS
		return 22'h208000 + 22'(a & 16'h7FFF);
	endfunction

	function automatic logic map_allow(input logic [15:0] a, input logic wr);
		if (a >= 16'h6000 && a < 16'hE000)
			return 1'b1;  // Work RAM takes reads and writes
		return !wr && (a >= 16'hE000 || a == `FDS_REG_DATA);
	endfunction

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Timer model built from the observed bus traffic
	always @(posedge clk) begin
		if (reset) begin
			cyc         <= 32'd0;
			deadline    <= 32'd0;
			latch       <= 16'd0;
			io_en       <= 1'b0;
			running     <= 1'b0;
			rep         <= 1'b0;
			tirq        <= 1'b0;
			stat_pend   <= 1'b0;
			disk_irq_en <= 1'b0;
		end else begin
			cyc       <= cyc + 32'd1;
			stat_pend <= bus.ce & bus.read & (bus.addr == `FDS_REG_STAT);
			if (running && cyc == deadline) begin
				tirq <= 1'b1;
				if (rep)
					deadline <= timer_deadline(cyc, latch);
				else
					running <= 1'b0;
			end
			if (bus.ce && bus.write) begin
				case (bus.addr)
					`FDS_REG_TLO:  latch[7:0] <= bus.wdata;
					`FDS_REG_THI:  latch[15:8] <= bus.wdata;
					`FDS_REG_IOEN: io_en <= bus.wdata[0];
					`FDS_REG_CTRL: disk_irq_en <= bus.wdata[7];
					`FDS_REG_TCTL: begin
						if (bus.wdata[1] && io_en) begin
							running  <= 1'b1;
							rep      <= bus.wdata[0];
							deadline <= timer_deadline(cyc, latch);
						end else begin
							running <= 1'b0;
							tirq    <= 1'b0;
						end
					end
					default: ;
				endcase
			end
			if (!io_en) begin
				running <= 1'b0;
				tirq    <= 1'b0;
			end
			if (stat_pend)
				tirq <= 1'b0;  // Second ce after the read
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			if (!disk_irq_en)
				compare(32'(irq), 32'(tirq), "timer irq");
			if (bus.ce && (bus.read || bus.write))
				compare(32'(prg_map.allow), 32'(map_allow(bus.addr, bus.write)),
					"map allow");
			if (bus.ce && bus.read) begin
				if (bus.addr == `FDS_REG_STAT)
					compare(32'(prg_dout), 32'(stat_byte(xfer_exp, 1'b0, tirq)), "status $4030");
				else if (bus.addr == `FDS_REG_DRIVE)
					compare(32'(prg_dout), 32'(drive_byte(ready_exp, eject)), "drive $4032");
				else if (bus.addr == `FDS_REG_EXT)
					compare(32'(prg_dout), 32'h80, "ext $4033");
				compare(32'(prg_drive), 32'(bus.addr == `FDS_REG_STAT ||
					bus.addr == `FDS_REG_DRIVE || bus.addr == `FDS_REG_EXT), "bus drive");
				if (bus.addr == `FDS_REG_DATA || bus.addr >= 16'h6000)
					compare(32'(prg_map.addr), 32'(map_addr(bus.addr, pos_exp, side_exp)),
						"mapped address");
			end
			if (cmp_en)
				compare(cmp_got, cmp_exp, "testbench value");
		end
	end

endmodule

// File: tb/fds_chk.sv
// Bound assertions on the FDS drive top for reset, bus drive and the transfer flag
`include "fds_consts.svh"

module fds_chk (
	input logic                  clk,
	input logic                  reset,
	input logic                  irq,
	input logic                  prg_drive,
	input logic                  xfer_flag,
	input fds_bus_pkg::cpu_bus_t bus
);
	timeunit 1ns;
	timeprecision 1ps;

	a_irq_reset: assert property (@(posedge clk) reset |=> !irq)
		else $error("irq is high right after a reset cycle");

	// Only the status registers put data on the bus
	a_drive: assert property (@(posedge clk) prg_drive |-> (bus.addr == `FDS_REG_STAT ||
		bus.addr == `FDS_REG_DRIVE || bus.addr == `FDS_REG_EXT))
		else $error("drive drove the data bus outside the status registers");

	a_xfer: assert property (@(posedge clk) disable iff (reset)
		(bus.ce && bus.read && bus.addr == `FDS_REG_DATA) |-> ##2 !xfer_flag)
		else $error("transfer flag still set two cycles after a data read");

endmodule

bind fds_top fds_chk u_chk (
	.clk       (clk),
	.reset     (reset),
	.irq       (irq),
	.prg_drive (prg_drive),
	.xfer_flag (status.xfer_flag),
	.bus       (bus)
);

// File: tb/tb_fds.sv
// Testbench top for the FDS drive that drives CPU bus cycles and disk bytes
`include "fds_consts.svh"

module tb_fds;
	timeunit 1ns;
	timeprecision 1ps;

	// Motor start to the end of two blocks fits well inside this
	localparam int max_cycles = 4 * (`FDS_PREGAP_FAST + 64 * (`FDS_BYTE_FAST + 1));

	logic                  clk;
	logic                  reset;
	fds_bus_pkg::cpu_bus_t bus;
	logic [7:0]            disk_byte;
	logic                  fast;
	logic                  eject;
	logic [1:0]            side_max;
	logic [7:0]            prg_dout;
	logic                  prg_drive;
	fds_bus_pkg::prg_map_t prg_map;
	logic                  irq;
	logic [15:0]           pos_exp;
	logic [1:0]            side_exp;
	logic                  xfer_exp;
	logic                  ready_exp;
	logic                  cmp_en;
	logic [31:0]           cmp_got;
	logic [31:0]           cmp_exp;
	int                    checks;
	int                    errors;
	int                    cycles = 0;
	int                    last_edge;
	integer                seed;

	fds_top uut (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus),
		.disk_byte (disk_byte),
		.fast      (fast),
		.eject     (eject),
		.side_max  (side_max),
		.prg_dout  (prg_dout),
		.prg_drive (prg_drive),
		.prg_map   (prg_map),
		.irq       (irq)
	);

	fds_monitor u_monitor (
		.clk       (clk),
		.reset     (reset),
		.bus       (bus),
		.prg_dout  (prg_dout),
		.prg_drive (prg_drive),
		.prg_map   (prg_map),
		.irq       (irq),
		.eject     (eject),
		.pos_exp   (pos_exp),
		.side_exp  (side_exp),
		.xfer_exp  (xfer_exp),
		.ready_exp (ready_exp),
		.cmp_en    (cmp_en),
		.cmp_got   (cmp_got),
		.cmp_exp   (cmp_exp),
		.checks    (checks),
		.errors    (errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic idle_bus();
		bus.addr  = 16'h0000;
		bus.wdata = 8'h00;
		bus.read  = 1'b0;
		bus.write = 1'b0;
		bus.ce    = 1'b1;  // Every clock is a bus cycle
	endtask

	// One bus cycle sampled on the next rising edge
	task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d, input logic wr);
		@(posedge clk);
		#1;
		bus.addr  = a;
		bus.wdata = d;
		bus.write = wr;
		bus.read  = ~wr;
		last_edge = cycles + 1;
		@(posedge clk);
		#1;
		idle_bus();
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		bus_cycle(a, d, 1'b1);
	endtask

	task automatic cpu_read(input logic [15:0] a);
		bus_cycle(a, 8'h00, 1'b0);
	endtask

	task automatic wait_irq();
		do begin
			@(posedge clk);
			#1;
		end while (!irq);
	endtask

	task automatic expect_value(input logic [31:0] got, input logic [31:0] exp);
		cmp_got = got;
		cmp_exp = exp;
		cmp_en  = 1'b1;
		@(negedge clk);
		#1 cmp_en = 1'b0;
	endtask

	task automatic run_timer(input logic rep);
		logic [15:0] lat;
		int          t0;
		lat = 16'd20 + 16'($random(seed) & 63);
		cpu_write(`FDS_REG_TLO, lat[7:0]);
		cpu_write(`FDS_REG_THI, lat[15:8]);
		cpu_write(`FDS_REG_IOEN, 8'h01);
		cpu_write(`FDS_REG_TCTL, {6'd0, 1'b1, rep});
		t0 = last_edge;
		wait_irq();
		expect_value(32'(cycles - t0), 32'(lat) + 32'd1);
		if (rep) begin
			t0 = cycles;
			cpu_read(`FDS_REG_STAT);
			wait_irq();
			expect_value(32'(cycles - t0), 32'(lat) + 32'd1);  // Period from the last expiry
		end else begin
			repeat (int'(lat) + 8) @(posedge clk);  // One-shot stays high
			cpu_read(`FDS_REG_STAT);
			repeat (int'(lat) + 8) @(posedge clk);  // No second expiry after the clear
		end
		cpu_read(`FDS_REG_STAT);
		cpu_write(`FDS_REG_TCTL, 8'h00);
	endtask

	task automatic check_map();
		for (int s = 0; s < 4; s++) begin
			cpu_write(`FDS_REG_SIDE, 8'(s));
			side_exp = (2'(s) > side_max) ? side_max : 2'(s);
			cpu_read(`FDS_REG_DATA);
			cpu_read(16'h6000 + 16'($random(seed) & 32'h7FFF));
			cpu_read(16'hE000 + 16'($random(seed) & 32'h1FFF));
		end
		cpu_read(`FDS_REG_STAT);
		cpu_read(`FDS_REG_EXT);
		eject = 1'b1;
		cpu_read(`FDS_REG_DRIVE);
		eject = 1'b0;
		cpu_read(`FDS_REG_DRIVE);
	endtask

	// Reads one block plus two bytes past its end
	task automatic read_block(input logic [7:0] type_byte, input logic [15:0] last);
		int prev;
		prev = 0;
		for (int i = 0; i <= int'(last) + 2; i++) begin
			if (i > 0 || !irq)
				wait_irq();
			if (i > 0)
				expect_value(32'(cycles - prev), 32'(`FDS_BYTE_FAST) + 32'd1);
			prev = cycles;
			disk_byte = (i == 0) ? type_byte : 8'($random(seed));
			cpu_read(`FDS_REG_DATA);
			if (i <= int'(last))
				pos_exp = pos_exp + 16'd1;
			@(posedge clk);
			#1;
			expect_value(32'(irq), 32'd0);
		end
	endtask

	task automatic run_disk();
		int t0;
		cpu_write(`FDS_REG_CTRL, 8'hC1);  // Motor, transfer, disk IRQ
		t0 = last_edge;
		ready_exp = 1'b1;
		wait_irq();
		expect_value(32'(cycles - t0), 32'(`FDS_PREGAP_FAST) + 32'(`FDS_BYTE_FAST) + 32'd2);
		read_block(8'h02, `FDS_BLK2_LAST);
		cpu_write(`FDS_REG_CTRL, 8'h81);
		cpu_write(`FDS_REG_CTRL, 8'hC1);  // New transfer start
		read_block(8'h03, `FDS_BLK3_LAST);
		wait_irq();
		xfer_exp = 1'b1;
		cpu_read(`FDS_REG_STAT);  // Flag still raised past the block end
		xfer_exp = 1'b0;
		cpu_read(`FDS_REG_DRIVE);
	endtask

	initial begin
		seed      = 32'haadb_3847;
		idle_bus();
		disk_byte = 8'h00;
		fast      = 1'b1;
		eject     = 1'b0;
		side_max  = 2'd1;
		pos_exp   = 16'd0;
		side_exp  = 2'd0;
		xfer_exp  = 1'b0;
		ready_exp = 1'b0;
		cmp_en    = 1'b0;
		cmp_got   = 32'd0;
		cmp_exp   = 32'd0;
		last_edge = 0;
		reset     = 1'b1;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;

		run_timer(1'b0);
		run_timer(1'b1);
		check_map();
		run_disk();

		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+common
common/fds_bus_pkg.sv
common/fds_disk_pkg.sv
src/fds_reg_ctrl.sv
src/fds_timer.sv
disk/fds_disk_xfer.sv
src/fds_bus_map.sv
src/fds_top.sv
tb/fds_monitor.sv
tb/fds_chk.sv
tb/tb_fds.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_fds \
	-f verilog.f -o sim_fds
status=0
./obj_dir/sim_fds > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
